// ==== include/core_macros.svh ====
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// data path and pc width
`define CORE_XLEN 32

// register file geometry
`define CORE_REG_AW 5
`define CORE_REG_NUM 32

// link value and sequential pc offset
`define CORE_PC_STEP 4

`endif

// ==== source/core_pkg.sv ====
`include "core_macros.svh"

package core_pkg;

    // bits 31:26 of the instruction word
    typedef enum logic [5:0] {
        OP_GRP       = 6'h00,
        OP_LU12I     = 6'h05,
        OP_PCADDU12I = 6'h07,
        OP_JIRL      = 6'h13,
        OP_B         = 6'h14,
        OP_BL        = 6'h15,
        OP_BEQ       = 6'h16,
        OP_BNE       = 6'h17,
        OP_BLT       = 6'h18,
        OP_BGE       = 6'h19,
        OP_BLTU      = 6'h1a,
        OP_BGEU      = 6'h1b
    } major_op_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_NOR,
        ALU_XOR,
        ALU_ANDN,
        ALU_ORN,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU,
        BR_JUMP,
        BR_JUMP_REG
    } br_cond_e;

    typedef struct packed {
        logic                  valid;
        logic [`CORE_XLEN-1:0] pc;
        logic [31:0]           inst;
    } fetch_t;

    typedef struct packed {
        logic                    valid;
        logic [`CORE_XLEN-1:0]   pc;
        alu_op_e                 alu_op;
        br_cond_e                br_cond;
        logic                    src1_is_pc;
        logic                    src2_is_imm;
        logic                    src2_is_4;
        logic                    we;
        logic [`CORE_REG_AW-1:0] dest;
        logic                    excp;
        logic [`CORE_XLEN-1:0]   rj_value;
        logic [`CORE_XLEN-1:0]   rkd_value;
        logic [`CORE_XLEN-1:0]   imm;
    } decoded_t;

    typedef struct packed {
        logic                    valid;
        logic [`CORE_XLEN-1:0]   pc;
        logic                    we;
        logic [`CORE_REG_AW-1:0] dest;
        logic [`CORE_XLEN-1:0]   value;
        logic                    excp;
        logic                    br_taken;
        logic [`CORE_XLEN-1:0]   br_target;
    } exec_t;

    // core output, same layout as the execute register
    typedef exec_t result_t;

endpackage

// ==== source/decode_stage.sv ====
`timescale 1ns/1ns
`include "core_macros.svh"

module decode_stage import core_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  fetch_t                  inst_in,
    output logic [`CORE_REG_AW-1:0] rf_raddr1,
    output logic [`CORE_REG_AW-1:0] rf_raddr2,
    input  logic [`CORE_XLEN-1:0]   rf_rdata1,
    input  logic [`CORE_XLEN-1:0]   rf_rdata2,
    input  exec_t                   exe_fwd,
    input  exec_t                   exe,
    output decoded_t                dec
);

    logic [31:0]             inst;
    logic [3:0]              op_25_22;
    logic [1:0]              op_21_20;
    logic [4:0]              op_19_15;
    logic [`CORE_REG_AW-1:0] rd;
    logic [`CORE_REG_AW-1:0] rj;
    logic [`CORE_REG_AW-1:0] rk;
    logic [`CORE_REG_AW-1:0] dest;
    logic [25:0]             i26;
    logic [`CORE_XLEN-1:0]   imm;

    logic     legal;
    logic     gr_we;
    logic     dst_is_r1;
    logic     cond_br;
    logic     need_rj;
    logic     need_rkd;
    logic     src1_is_pc;
    logic     src2_is_imm;
    logic     src2_is_4;
    logic     imm_ui5;
    logic     imm_si12;
    logic     imm_ui12;
    logic     imm_si20;
    logic     imm_si16;
    logic     imm_si26;
    alu_op_e  alu_op;
    br_cond_e br_cond;
    decoded_t dec_next;

    // youngest older producer wins, then the register file
    function automatic logic [`CORE_XLEN-1:0] fwd_pick(
        input logic [`CORE_REG_AW-1:0] addr,
        input logic                    need,
        input exec_t                   young,
        input exec_t                   old,
        input logic [`CORE_XLEN-1:0]   rf_data
    );
        logic young_hit;
        logic old_hit;
        young_hit = need && young.valid && young.we && young.dest != '0 && young.dest == addr;
        old_hit   = need && old.valid && old.we && old.dest != '0 && old.dest == addr;
        if (young_hit) begin
            return young.value;
        end else if (old_hit) begin
            return old.value;
        end
        return rf_data;
    endfunction

    assign inst     = inst_in.inst;
    assign op_25_22 = inst[25:22];
    assign op_21_20 = inst[21:20];
    assign op_19_15 = inst[19:15];
    assign rd       = inst[4:0];
    assign rj       = inst[9:5];
    assign rk       = inst[14:10];
    assign i26      = {inst[9:0], inst[25:10]};

    always_comb begin
        legal       = 1'b1;
        gr_we       = 1'b1;
        dst_is_r1   = 1'b0;
        need_rj     = 1'b0;
        need_rkd    = 1'b0;
        src1_is_pc  = 1'b0;
        src2_is_imm = 1'b0;
        src2_is_4   = 1'b0;
        imm_ui5     = 1'b0;
        imm_si12    = 1'b0;
        imm_ui12    = 1'b0;
        imm_si20    = 1'b0;
        imm_si16    = 1'b0;
        imm_si26    = 1'b0;
        alu_op      = ALU_ADD;
        br_cond     = BR_NONE;
        case (major_op_e'(inst[31:26]))
            OP_GRP: begin
                need_rj = 1'b1;
                if (op_25_22 == 4'h0 && op_21_20 == 2'h1) begin
                    // three-register forms
                    need_rkd = 1'b1;
                    case (op_19_15)
                        5'h00: alu_op = ALU_ADD;
                        5'h02: alu_op = ALU_SUB;
                        5'h04: alu_op = ALU_SLT;
                        5'h05: alu_op = ALU_SLTU;
                        5'h08: alu_op = ALU_NOR;
                        5'h09: alu_op = ALU_AND;
                        5'h0a: alu_op = ALU_OR;
                        5'h0b: alu_op = ALU_XOR;
                        5'h0c: alu_op = ALU_ORN;
                        5'h0d: alu_op = ALU_ANDN;
                        5'h0e: alu_op = ALU_SLL;
                        5'h0f: alu_op = ALU_SRL;
                        5'h10: alu_op = ALU_SRA;
                        default: legal = 1'b0;
                    endcase
                end else if (op_25_22 == 4'h1 && op_21_20 == 2'h0) begin
                    // shift by ui5
                    src2_is_imm = 1'b1;
                    imm_ui5     = 1'b1;
                    case (op_19_15)
                        5'h01: alu_op = ALU_SLL;
                        5'h09: alu_op = ALU_SRL;
                        5'h11: alu_op = ALU_SRA;
                        default: legal = 1'b0;
                    endcase
                end else begin
                    src2_is_imm = 1'b1;
                    imm_si12    = op_25_22 inside {4'h8, 4'h9, 4'ha};
                    imm_ui12    = op_25_22 inside {4'hd, 4'he, 4'hf};
                    case (op_25_22)
                        4'h8: alu_op = ALU_SLT;
                        4'h9: alu_op = ALU_SLTU;
                        4'ha: alu_op = ALU_ADD;
                        4'hd: alu_op = ALU_AND;
                        4'he: alu_op = ALU_OR;
                        4'hf: alu_op = ALU_XOR;
                        default: legal = 1'b0;
                    endcase
                end
            end
            OP_LU12I: begin
                legal       = !inst[25];
                src2_is_imm = 1'b1;
                imm_si20    = 1'b1;
                alu_op      = ALU_LUI;
            end
            OP_PCADDU12I: begin
                legal       = !inst[25];
                src1_is_pc  = 1'b1;
                src2_is_imm = 1'b1;
                imm_si20    = 1'b1;
            end
            OP_JIRL: begin
                need_rj    = 1'b1;
                src1_is_pc = 1'b1;
                src2_is_4  = 1'b1;
                imm_si16   = 1'b1;
                br_cond    = BR_JUMP_REG;
            end
            OP_B: begin
                gr_we    = 1'b0;
                imm_si26 = 1'b1;
                br_cond  = BR_JUMP;
            end
            OP_BL: begin
                dst_is_r1  = 1'b1;
                src1_is_pc = 1'b1;
                src2_is_4  = 1'b1;
                imm_si26   = 1'b1;
                br_cond    = BR_JUMP;
            end
            OP_BEQ:  br_cond = BR_EQ;
            OP_BNE:  br_cond = BR_NE;
            OP_BLT:  br_cond = BR_LT;
            OP_BGE:  br_cond = BR_GE;
            OP_BLTU: br_cond = BR_LTU;
            OP_BGEU: br_cond = BR_GEU;
            default: legal = 1'b0;
        endcase

        // conditional branches compare rj against rd
        cond_br = br_cond inside {BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU};
        if (cond_br) begin
            gr_we    = 1'b0;
            need_rj  = 1'b1;
            need_rkd = 1'b1;
            imm_si16 = 1'b1;
        end
    end

    assign dest      = dst_is_r1 ? `CORE_REG_AW'd1 : rd;
    assign rf_raddr1 = rj;
    assign rf_raddr2 = cond_br ? rd : rk;

    assign imm = ({`CORE_XLEN{imm_ui5}}  & {27'b0, inst[14:10]})              |
                 ({`CORE_XLEN{imm_si12}} & {{20{inst[21]}}, inst[21:10]})     |
                 ({`CORE_XLEN{imm_ui12}} & {20'b0, inst[21:10]})              |
                 ({`CORE_XLEN{imm_si20}} & {inst[24:5], 12'b0})               |
                 ({`CORE_XLEN{imm_si16}} & {{14{inst[25]}}, inst[25:10], 2'b0}) |
                 ({`CORE_XLEN{imm_si26}} & {{4{i26[25]}}, i26, 2'b0});

    always_comb begin
        dec_next.valid       = inst_in.valid;
        dec_next.pc          = inst_in.pc;
        dec_next.alu_op      = alu_op;
        dec_next.br_cond     = legal ? br_cond : BR_NONE;
        dec_next.src1_is_pc  = src1_is_pc;
        dec_next.src2_is_imm = src2_is_imm;
        dec_next.src2_is_4   = src2_is_4;
        // writes to r0 are dropped here
        dec_next.we          = legal && gr_we && dest != '0;
        dec_next.dest        = dest;
        dec_next.excp        = !legal;
        dec_next.rj_value    = fwd_pick(rf_raddr1, need_rj, exe_fwd, exe, rf_rdata1);
        dec_next.rkd_value   = fwd_pick(rf_raddr2, need_rkd, exe_fwd, exe, rf_rdata2);
        dec_next.imm         = imm;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec <= '0;
        end else begin
            dec <= dec_next;
        end
    end

endmodule

// ==== source/execute_stage.sv ====
`timescale 1ns/1ns
`include "core_macros.svh"

module execute_stage import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  decoded_t dec,
    output exec_t    exe_fwd,
    output exec_t    exe
);

    logic [`CORE_XLEN-1:0] src1;
    logic [`CORE_XLEN-1:0] src2;
    logic [`CORE_XLEN-1:0] alu_result;
    logic [`CORE_XLEN-1:0] target;
    logic                  rj_eq_rkd;
    logic                  rj_lt_rkd;
    logic                  rj_ltu_rkd;
    logic                  taken;
    logic                  is_branch;

    assign src1 = dec.src1_is_pc ? dec.pc : dec.rj_value;
    assign src2 = dec.src2_is_4   ? `CORE_XLEN'(`CORE_PC_STEP) :
                  dec.src2_is_imm ? dec.imm : dec.rkd_value;

    always_comb begin
        case (dec.alu_op)
            ALU_ADD:  alu_result = src1 + src2;
            ALU_SUB:  alu_result = src1 - src2;
            ALU_SLT:  alu_result = {31'b0, $signed(src1) < $signed(src2)};
            ALU_SLTU: alu_result = {31'b0, src1 < src2};
            ALU_AND:  alu_result = src1 & src2;
            ALU_OR:   alu_result = src1 | src2;
            ALU_NOR:  alu_result = ~(src1 | src2);
            ALU_XOR:  alu_result = src1 ^ src2;
            ALU_ANDN: alu_result = src1 & ~src2;
            ALU_ORN:  alu_result = src1 | ~src2;
            ALU_SLL:  alu_result = src1 << src2[4:0];
            ALU_SRL:  alu_result = src1 >> src2[4:0];
            ALU_SRA:  alu_result = $signed(src1) >>> src2[4:0];
            ALU_LUI:  alu_result = dec.imm;
            default:  alu_result = '0;
        endcase
    end

    // branch compare always uses the register operands
    assign rj_eq_rkd  = dec.rj_value == dec.rkd_value;
    assign rj_lt_rkd  = $signed(dec.rj_value) < $signed(dec.rkd_value);
    assign rj_ltu_rkd = dec.rj_value < dec.rkd_value;

    always_comb begin
        case (dec.br_cond)
            BR_EQ:       taken = rj_eq_rkd;
            BR_NE:       taken = !rj_eq_rkd;
            BR_LT:       taken = rj_lt_rkd;
            BR_GE:       taken = !rj_lt_rkd;
            BR_LTU:      taken = rj_ltu_rkd;
            BR_GEU:      taken = !rj_ltu_rkd;
            BR_JUMP:     taken = 1'b1;
            BR_JUMP_REG: taken = 1'b1;
            default:     taken = 1'b0;
        endcase
    end

    assign is_branch = dec.br_cond != BR_NONE && !dec.excp;
    assign target    = (dec.br_cond == BR_JUMP_REG) ? dec.rj_value + dec.imm : dec.pc + dec.imm;

    always_comb begin
        exe_fwd.valid     = dec.valid;
        exe_fwd.pc        = dec.pc;
        exe_fwd.we        = dec.valid && dec.we && !dec.excp;
        exe_fwd.dest      = dec.dest;
        exe_fwd.value     = exe_fwd.we ? alu_result : '0;
        exe_fwd.excp      = dec.valid && dec.excp;
        exe_fwd.br_taken  = dec.valid && is_branch && taken;
        exe_fwd.br_target = is_branch ? target : '0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exe <= '0;
        end else begin
            exe <= exe_fwd;
        end
    end

endmodule

// ==== source/writeback_stage.sv ====
`timescale 1ns/1ns
`include "core_macros.svh"

module writeback_stage import core_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  exec_t                   exe,
    input  logic [`CORE_REG_AW-1:0] rf_raddr1,
    input  logic [`CORE_REG_AW-1:0] rf_raddr2,
    output logic [`CORE_XLEN-1:0]   rf_rdata1,
    output logic [`CORE_XLEN-1:0]   rf_rdata2,
    output result_t                 res
);

    logic [`CORE_XLEN-1:0] rf [`CORE_REG_NUM];
    logic                  rf_we;

    assign rf_we = exe.valid && exe.we && exe.dest != '0;

    // same edge as the result register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CORE_REG_NUM; i++) begin
                rf[i] <= '0;
            end
        end else if (rf_we) begin
            rf[exe.dest] <= exe.value;
        end
    end

    // r0 is hardwired
    assign rf_rdata1 = (rf_raddr1 == '0) ? '0 : rf[rf_raddr1];
    assign rf_rdata2 = (rf_raddr2 == '0) ? '0 : rf[rf_raddr2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res <= '0;
        end else begin
            res <= exe;
        end
    end

endmodule

// ==== source/int_core.sv ====
`timescale 1ns/1ns
`include "core_macros.svh"

module int_core import core_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  fetch_t  inst_in,
    output result_t res
);

    logic [`CORE_REG_AW-1:0] rf_raddr1;
    logic [`CORE_REG_AW-1:0] rf_raddr2;
    logic [`CORE_XLEN-1:0]   rf_rdata1;
    logic [`CORE_XLEN-1:0]   rf_rdata2;
    decoded_t                dec;
    exec_t                   exe_fwd;
    exec_t                   exe;

    decode_stage i_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .inst_in   (inst_in),
        .rf_raddr1 (rf_raddr1),
        .rf_raddr2 (rf_raddr2),
        .rf_rdata1 (rf_rdata1),
        .rf_rdata2 (rf_rdata2),
        .exe_fwd   (exe_fwd),
        .exe       (exe),
        .dec       (dec)
    );

    execute_stage i_execute (
        .clk     (clk),
        .rst_n   (rst_n),
        .dec     (dec),
        .exe_fwd (exe_fwd),
        .exe     (exe)
    );

    // also holds the register file
    writeback_stage i_writeback (
        .clk       (clk),
        .rst_n     (rst_n),
        .exe       (exe),
        .rf_raddr1 (rf_raddr1),
        .rf_raddr2 (rf_raddr2),
        .rf_rdata1 (rf_rdata1),
        .rf_rdata2 (rf_rdata2),
        .res       (res)
    );

endmodule

// ==== sim/core_assert.sv ====
`timescale 1ns/1ns

module core_assert import core_pkg::*; (
    input logic    clk,
    input logic    rst_n,
    input fetch_t  inst_in,
    input result_t res
);

    // fixed latency of three edges, no result without an instruction
    a_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        res.valid == $past(inst_in.valid, 3)
    ) else $error("result strobe is not three edges after its instruction");

    a_excp_no_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        res.excp |-> !res.we && !res.br_taken
    ) else $error("exception result writes a register or branches");

    a_we_dest: assert property (
        @(posedge clk) disable iff (!rst_n)
        res.we |-> res.dest != '0
    ) else $error("register write reported for r0");

    a_taken_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        res.br_taken |-> res.valid
    ) else $error("branch taken without a valid result");

endmodule

bind int_core core_assert i_assert (.*);

// ==== sim/core_tb.sv ====
`timescale 1ns/1ns
`include "core_macros.svh"

module core_tb import core_pkg::*; ();

    logic    clk;
    logic    rst_n;
    fetch_t  inst_in;
    result_t res;

    logic [31:0]           lfsr;
    logic [`CORE_XLEN-1:0] pc;
    logic [`CORE_XLEN-1:0] model_rf [`CORE_REG_NUM];
    result_t               exp_q [$];
    string                 name_q [$];

    // padded to power-of-two tables so a plain bit draw indexes them
    localparam logic [4:0] REG_SUBS [16] = '{5'h00, 5'h02, 5'h04, 5'h05, 5'h08, 5'h09, 5'h0a,
        5'h0b, 5'h0c, 5'h0d, 5'h0e, 5'h0f, 5'h10, 5'h00, 5'h02, 5'h10};
    localparam logic [3:0] IMM_OPS [8] = '{4'h8, 4'h9, 4'ha, 4'hd, 4'he, 4'hf, 4'ha, 4'he};
    localparam logic [4:0] SHIFT_SUBS [4] = '{5'h01, 5'h09, 5'h11, 5'h11};
    localparam logic [5:0] BR_OPS [16] = '{6'h16, 6'h17, 6'h18, 6'h19, 6'h1a, 6'h1b, 6'h16,
        6'h17, 6'h18, 6'h19, 6'h1a, 6'h1b, 6'h14, 6'h15, 6'h13, 6'h13};

    int_core i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .inst_in (inst_in),
        .res     (res)
    );

    always #2 clk = ~clk;

    // fibonacci lfsr over taps 32 22 2 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // small register set so neighbours depend on each other
    function automatic logic [4:0] pick_reg();
        logic [31:0] v;
        v = take_bits(3);
        return v[4:0];
    endfunction

    // architectural reference, executed strictly in program order
    function automatic result_t model_step(input logic [31:0] ipc, input logic [31:0] inst);
        result_t     r;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] d;
        logic [31:0] si12;
        logic [31:0] ui12;
        logic [31:0] offs16;
        logic [31:0] offs26;
        logic [31:0] wdata;
        logic [31:0] target;
        logic        ok;
        logic        wr;
        logic        br;
        logic        taken;
        r      = '0;
        rd     = inst[4:0];
        a      = model_rf[inst[9:5]];
        b      = model_rf[inst[14:10]];
        d      = model_rf[inst[4:0]];
        si12   = {{20{inst[21]}}, inst[21:10]};
        ui12   = {20'b0, inst[21:10]};
        offs16 = {{14{inst[25]}}, inst[25:10], 2'b00};
        offs26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
        ok     = 1'b1;
        wr     = 1'b1;
        br     = 1'b0;
        taken  = 1'b0;
        target = '0;
        wdata  = ipc + 32'd4;
        case (inst[31:26])
            6'h00: begin
                if (inst[25:20] == 6'b000001) begin
                    case (inst[19:15])
                        5'h00: wdata = a + b;
                        5'h02: wdata = a - b;
                        5'h04: wdata = {31'b0, $signed(a) < $signed(b)};
                        5'h05: wdata = {31'b0, a < b};
                        5'h08: wdata = ~(a | b);
                        5'h09: wdata = a & b;
                        5'h0a: wdata = a | b;
                        5'h0b: wdata = a ^ b;
                        5'h0c: wdata = a | ~b;
                        5'h0d: wdata = a & ~b;
                        5'h0e: wdata = a << b[4:0];
                        5'h0f: wdata = a >> b[4:0];
                        5'h10: wdata = $signed(a) >>> b[4:0];
                        default: ok = 1'b0;
                    endcase
                end else if (inst[25:20] == 6'b000100) begin
                    case (inst[19:15])
                        5'h01: wdata = a << inst[14:10];
                        5'h09: wdata = a >> inst[14:10];
                        5'h11: wdata = $signed(a) >>> inst[14:10];
                        default: ok = 1'b0;
                    endcase
                end else begin
                    case (inst[25:22])
                        4'h8: wdata = {31'b0, $signed(a) < $signed(si12)};
                        4'h9: wdata = {31'b0, a < si12};
                        4'ha: wdata = a + si12;
                        4'hd: wdata = a & ui12;
                        4'he: wdata = a | ui12;
                        4'hf: wdata = a ^ ui12;
                        default: ok = 1'b0;
                    endcase
                end
            end
            6'h05: begin
                ok    = !inst[25];
                wdata = {inst[24:5], 12'b0};
            end
            6'h07: begin
                ok    = !inst[25];
                wdata = ipc + {inst[24:5], 12'b0};
            end
            6'h13: begin
                br     = 1'b1;
                taken  = 1'b1;
                target = a + offs16;
            end
            6'h14, 6'h15: begin
                wr     = inst[26];
                rd     = inst[26] ? 5'd1 : rd;
                br     = 1'b1;
                taken  = 1'b1;
                target = ipc + offs26;
            end
            6'h16, 6'h17, 6'h18, 6'h19, 6'h1a, 6'h1b: begin
                wr     = 1'b0;
                br     = 1'b1;
                target = ipc + offs16;
                case (inst[28:26])
                    3'h6: taken = a == d;
                    3'h7: taken = a != d;
                    3'h0: taken = $signed(a) < $signed(d);
                    3'h1: taken = $signed(a) >= $signed(d);
                    3'h2: taken = a < d;
                    default: taken = a >= d;
                endcase
            end
            default: ok = 1'b0;
        endcase
        r.valid     = 1'b1;
        r.pc        = ipc;
        r.dest      = rd;
        r.excp      = !ok;
        r.we        = ok && wr && rd != 5'd0;
        r.value     = r.we ? wdata : 32'd0;
        r.br_taken  = ok && br && taken;
        r.br_target = (ok && br) ? target : 32'd0;
        if (r.we) begin
            model_rf[rd] = wdata;
        end
        return r;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic compare_word(input string name, input logic [`CORE_XLEN-1:0] exp_w,
                                input logic [`CORE_XLEN-1:0] act_w);
        if (exp_w !== act_w) begin
            abort_run($sformatf("Error: %s expected %h actual %h", name, exp_w, act_w));
        end
    endtask

    task automatic compare_result(input string name, input result_t exp_r, input result_t act_r);
        compare_word({name, " pc"}, exp_r.pc, act_r.pc);
        if (exp_r.we !== act_r.we || exp_r.dest !== act_r.dest) begin
            abort_run($sformatf("Error: %s we/dest expected %b/r%0d actual %b/r%0d",
                                name, exp_r.we, exp_r.dest, act_r.we, act_r.dest));
        end
        if (exp_r.excp !== act_r.excp || exp_r.br_taken !== act_r.br_taken) begin
            abort_run($sformatf("Error: %s excp/br_taken expected %b/%b actual %b/%b",
                                name, exp_r.excp, exp_r.br_taken, act_r.excp, act_r.br_taken));
        end
        compare_word({name, " value"}, exp_r.value, act_r.value);
        compare_word({name, " br_target"}, exp_r.br_target, act_r.br_target);
    endtask

    // res is stable at the falling edge
    always @(negedge clk) begin
        if (res.valid) begin
            if (!rst_n || exp_q.size() == 0) begin
                abort_run("a result strobe appeared with no instruction in flight");
            end else begin
                compare_result(name_q.pop_front(), exp_q.pop_front(), res);
            end
        end
    end

    task automatic idle_cycle();
        @(posedge clk);
        inst_in <= '0;
    endtask

    task automatic issue(input string name, input logic [31:0] inst);
        @(posedge clk);
        inst_in <= '{valid: 1'b1, pc: pc, inst: inst};
        exp_q.push_back(model_step(pc, inst));
        name_q.push_back(name);
        pc = pc + `CORE_PC_STEP;
    endtask

    task automatic drain(input string name);
        int cycles;
        idle_cycle();
        cycles = 0;
        while (exp_q.size() != 0) begin
            if (cycles == 20) begin
                abort_run($sformatf("timeout while waiting for the %s results to drain", name));
            end
            @(posedge clk);
            cycles++;
        end
    endtask

    task automatic load_regs();
        logic [31:0] v;
        for (int r = 1; r < 8; r++) begin
            v = take_bits(32);
            issue("load", {6'h05, 1'b0, v[31:12], 5'(r)});
            issue("load", {6'h00, 4'he, v[11:0], 5'(r), 5'(r)});
        end
        drain("load");
    endtask

    task automatic random_ops(input string name, input int kind, input int n);
        logic [31:0] k;
        logic [31:0] v;
        logic [4:0]  rd;
        logic [4:0]  rj;
        for (int i = 0; i < n; i++) begin
            if (take_bits(2) == 0) begin
                idle_cycle();
            end
            k  = take_bits(4);
            v  = take_bits(26);
            rd = pick_reg();
            rj = pick_reg();
            if (kind == 0) begin
                issue(name, {6'h00, 6'b000001, REG_SUBS[k[3:0]], pick_reg(), rj, rd});
            end else if (kind == 1) begin
                if (k < 8) begin
                    issue(name, {6'h00, IMM_OPS[k[2:0]], v[11:0], rj, rd});
                end else if (k < 12) begin
                    issue(name, {6'h00, 6'b000100, SHIFT_SUBS[k[1:0]], v[4:0], rj, rd});
                end else begin
                    issue(name, {k < 14 ? 6'h05 : 6'h07, 1'b0, v[19:0], rd});
                end
            end else if (kind == 2) begin
                if (BR_OPS[k[3:0]] == 6'h14 || BR_OPS[k[3:0]] == 6'h15) begin
                    issue(name, {BR_OPS[k[3:0]], v[15:0], v[25:16]});
                end else begin
                    issue(name, {BR_OPS[k[3:0]], v[15:0], rj, rd});
                end
            end else begin
                v = take_bits(32);
                // top opcode bit set is never a kept encoding
                if (k[0]) begin
                    v[31] = 1'b1;
                end
                issue(name, v);
            end
        end
        drain(name);
    endtask

    initial begin
        clk     = 1'b0;
        rst_n   = 1'b0;
        inst_in = '0;
        lfsr    = 32'hec13;
        pc      = 32'h1c00_0000;
        for (int i = 0; i < `CORE_REG_NUM; i++) begin
            model_rf[i] = '0;
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        repeat (6) @(posedge clk);
        load_regs();
        random_ops("alu_reg", 0, 300);
        random_ops("alu_imm", 1, 300);
        random_ops("branch", 2, 300);
        random_ops("illegal", 3, 100);
        random_ops("after_illegal", 0, 100);
        // writes to r0, then reads of it back to back
        issue("r0_write", {6'h00, 6'b000001, 5'h00, 5'd2, 5'd1, 5'd0});
        issue("r0_write", {6'h05, 1'b0, 20'hfffff, 5'd0});
        issue("r0_write", {6'h13, 16'h0004, 5'd1, 5'd0});
        issue("r0_read", {6'h00, 6'b000001, 5'h0a, 5'd0, 5'd0, 5'd5});
        issue("r0_read", {6'h00, 6'b000001, 5'h00, 5'd0, 5'd3, 5'd6});
        drain("r0");
        for (int i = 0; i < `CORE_REG_NUM; i++) begin
            compare_word($sformatf("final r%0d", i), model_rf[i], i_dut.i_writeback.rf[5'(i)]);
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+include
source/core_pkg.sv
source/decode_stage.sv
source/execute_stage.sv
source/writeback_stage.sv
source/int_core.sv
sim/core_assert.sv
sim/core_tb.sv

// ==== Makefile ====
SIM := obj_dir/Vcore_tb
SRCS := $(shell grep -v '^+' all.f) include/core_macros.svh

.PHONY: run clean

run: $(SIM)
	./$(SIM) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Test failures found" sim.log; then exit 1; fi

$(SIM): all.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module core_tb -f all.f

clean:
	rm -rf obj_dir sim.log
